/* verilog/cpu_pkg.sv */
package cpu_pkg;

    // *************************************************************************
    // widths
    // *************************************************************************
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int IMM_W      = 16;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] regsel_t;

    // instruction field positions
    localparam int OP_HI    = 31;
    localparam int OP_LO    = 26;
    localparam int RS_HI    = 25;
    localparam int RS_LO    = 21;
    localparam int RT_HI    = 20;
    localparam int RT_LO    = 16;
    localparam int RD_HI    = 15;
    localparam int RD_LO    = 11;
    localparam int FUNCT_HI = 5;
    localparam int FUNCT_LO = 0;
    localparam int IMM_HI   = 15;
    localparam int IMM_LO   = 0;

    // program counter
    localparam word_t PC_INIT = '0;
    localparam word_t PC_STEP = 32'd4;

    // *************************************************************************
    // encodings
    // *************************************************************************
    typedef enum logic [5:0] {
        RTYPE = 6'b000000,
        ADDIU = 6'b001001,
        ANDI  = 6'b001100,
        ORI   = 6'b001101,
        LUI   = 6'b001111,
        LW    = 6'b100011,
        SW    = 6'b101011,
        HALT  = 6'b111111
    } opcode_t;

    typedef enum logic [5:0] {
        ADDU = 6'b100001,
        SUBU = 6'b100011,
        AND  = 6'b100100,
        OR   = 6'b100101,
        XOR  = 6'b100110,
        SLT  = 6'b101010
    } funct_t;

    // zero value doubles as the bubble op
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_LUI = 3'd6
    } aluop_t;

    // all zero means bubble
    typedef struct packed {
        logic   reg_write;
        logic   reg_dst_rd;
        logic   alu_src_imm;
        logic   zero_extend;
        logic   mem_to_reg;
        logic   mem_read;
        logic   mem_write;
        logic   halt;
        aluop_t alu_op;
    } ctrl_t;

endpackage

/* verilog/pipe_if.sv */
`timescale 1ns/10ps

// decode to execute bundle, the ID/EX register itself
interface id_ex_if
    import cpu_pkg::*;
();
    ctrl_t   ctrl;
    word_t   rdat1;
    word_t   rdat2;
    word_t   imm;
    regsel_t rs;
    regsel_t rt;
    regsel_t rd;

    modport decode (
        output ctrl, rdat1, rdat2, imm, rs, rt, rd
    );

    modport execute (
        input ctrl, rdat1, rdat2, imm, rs, rt, rd
    );

    // load-use check only needs the load flag and its target
    modport hazard (
        input ctrl, rt
    );
endinterface

// execute to memory bundle, the EX/MEM register
interface ex_mem_if
    import cpu_pkg::*;
();
    ctrl_t   ctrl;
    word_t   alu_out;
    word_t   store_data;
    regsel_t reg_sel;

    modport execute (
        output ctrl, alu_out, store_data, reg_sel
    );

    modport memory (
        input ctrl, alu_out, store_data, reg_sel
    );
endinterface

// writeback result, fans out to the register file and forwarding
interface wb_if
    import cpu_pkg::*;
();
    logic    reg_write;
    regsel_t reg_sel;
    word_t   wdat;

    modport memory (output reg_write, reg_sel, wdat);
    modport decode (input reg_write, reg_sel, wdat);
    modport execute (input reg_write, reg_sel, wdat);
endinterface

/* verilog/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage
    import cpu_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    input  logic  move,
    input  logic  stall,
    input  logic  halt,
    input  word_t imem_load,
    output word_t imem_addr,
    output word_t ifid_instr
);

    word_t pc;
    logic  advance;

    // a load-use stall freezes the front end for one move
    assign advance = move && !stall;

    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
            pc <= PC_INIT;
        else if (advance && !halt)
            pc <= pc + PC_STEP;
    end

    assign imem_addr = pc;

    // IF/ID register, zero decodes as a bubble
    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
            ifid_instr <= '0;
        else if (advance)
        begin
            if (halt)
                ifid_instr <= '0;
            else
                ifid_instr <= imem_load;
        end
    end

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage
    import cpu_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    input  logic  move,
    input  logic  stall,
    input  word_t ifid_instr,
    id_ex_if.decode id_ex,
    wb_if.decode    wb
);

    opcode_t opcode;
    funct_t  funct;
    ctrl_t   ctrl;
    word_t   imm_ext;
    regsel_t rs;
    regsel_t rt;
    logic [IMM_W-1:0] imm;
    word_t   regs [NUM_REGS];

    assign opcode = opcode_t'(ifid_instr[OP_HI:OP_LO]);
    assign funct  = funct_t'(ifid_instr[FUNCT_HI:FUNCT_LO]);
    assign rs     = ifid_instr[RS_HI:RS_LO];
    assign rt     = ifid_instr[RT_HI:RT_LO];
    assign imm    = ifid_instr[IMM_HI:IMM_LO];

    // *************************************************************************
    // control decode
    // *************************************************************************
    always_comb
    begin
        ctrl = '0;
        case (opcode)
            RTYPE:
            begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst_rd = 1'b1;
                case (funct)
                    ADDU:    ctrl.alu_op = ALU_ADD;
                    SUBU:    ctrl.alu_op = ALU_SUB;
                    AND:     ctrl.alu_op = ALU_AND;
                    OR:      ctrl.alu_op = ALU_OR;
                    XOR:     ctrl.alu_op = ALU_XOR;
                    SLT:     ctrl.alu_op = ALU_SLT;
                    // unknown function, also the all-zero word
                    default: ctrl = '0;
                endcase
            end
            ADDIU, LUI, ANDI, ORI, LW:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.zero_extend = (opcode == ANDI) || (opcode == ORI);
                ctrl.mem_to_reg  = (opcode == LW);
                ctrl.mem_read    = (opcode == LW);
                if (opcode == ANDI)
                    ctrl.alu_op = ALU_AND;
                else if (opcode == ORI)
                    ctrl.alu_op = ALU_OR;
                else if (opcode == LUI)
                    ctrl.alu_op = ALU_LUI;
            end
            SW:
            begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            HALT:    ctrl.halt = 1'b1;
            default: ctrl = '0;
        endcase
    end

    assign imm_ext = ctrl.zero_extend ? {{(WORD_W-IMM_W){1'b0}}, imm}
                                      : {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};

    // *************************************************************************
    // register file, r0 stays zero
    // *************************************************************************
    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
            regs <= '{default: '0};
        else if (move && wb.reg_write && (wb.reg_sel != '0))
            regs[wb.reg_sel] <= wb.wdat;
    end

    // write-through so ID sees the value retiring this cycle
    function automatic word_t read_reg(input regsel_t sel);
        word_t val;
        if (sel == '0)
            val = '0;
        else if (wb.reg_write && (wb.reg_sel == sel))
            val = wb.wdat;
        else
            val = regs[sel];
        return val;
    endfunction

    // ID/EX control, bubble on load-use stall
    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
            id_ex.ctrl <= '0;
        else if (move)
            id_ex.ctrl <= stall ? '0 : ctrl;
    end

    // ID/EX payload
    always_ff @(posedge CLK)
    begin
        if (move)
        begin
            id_ex.rdat1 <= read_reg(rs);
            id_ex.rdat2 <= read_reg(rt);
            id_ex.imm   <= imm_ext;
            id_ex.rs    <= rs;
            id_ex.rt    <= rt;
            id_ex.rd    <= ifid_instr[RD_HI:RD_LO];
        end
    end

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage
    import cpu_pkg::*;
(
    input  logic CLK,
    input  logic nRST,
    input  logic move,
    input  logic dhit,
    id_ex_if.execute  id_ex,
    ex_mem_if.execute ex_mem,
    wb_if.execute     wb
);

    word_t   op_a;
    word_t   op_b;
    word_t   fwd_b;
    word_t   alu_out;
    regsel_t dest;

    // MEM result wins over WB and r0 never forwards
    function automatic word_t forward(input regsel_t src, input word_t reg_val);
        word_t val;
        val = reg_val;
        if (wb.reg_write && (wb.reg_sel != '0) && (wb.reg_sel == src))
            val = wb.wdat;
        if (ex_mem.ctrl.reg_write && (ex_mem.reg_sel != '0) && (ex_mem.reg_sel == src))
            val = ex_mem.alu_out;
        return val;
    endfunction

    always_comb
    begin
        op_a  = forward(id_ex.rs, id_ex.rdat1);
        fwd_b = forward(id_ex.rt, id_ex.rdat2);
    end

    assign op_b  = id_ex.ctrl.alu_src_imm ? id_ex.imm : fwd_b;

    // *************************************************************************
    // ALU
    // *************************************************************************
    always_comb
    begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_SLT: alu_out = {{(WORD_W-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            ALU_LUI: alu_out = {op_b[IMM_W-1:0], {IMM_W{1'b0}}};
            default: alu_out = op_a + op_b;
        endcase
    end

    assign dest = id_ex.ctrl.reg_dst_rd ? id_ex.rd : id_ex.rt;

    // a served data access drops its EX/MEM strobe even when frozen
    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
            ex_mem.ctrl <= '0;
        else if (move)
            ex_mem.ctrl <= id_ex.ctrl;
        else if (dhit)
        begin
            ex_mem.ctrl.mem_read  <= 1'b0;
            ex_mem.ctrl.mem_write <= 1'b0;
        end
    end

    // EX/MEM payload
    always_ff @(posedge CLK)
    begin
        if (move)
        begin
            ex_mem.alu_out    <= alu_out;
            ex_mem.store_data <= fwd_b;
            ex_mem.reg_sel    <= dest;
        end
    end

endmodule

/* verilog/memory_stage.sv */
`timescale 1ns/10ps

module memory_stage
    import cpu_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    input  logic  move,
    input  logic  dhit,
    input  word_t dmem_load,
    ex_mem_if.memory ex_mem,
    wb_if.memory     wb,
    output logic  dmem_ren,
    output logic  dmem_wen,
    output word_t dmem_addr,
    output word_t dmem_store,
    output logic  halt
);

    word_t   load_hold;
    word_t   load_data;
    logic    mw_reg_write;
    logic    mw_mem_to_reg;
    regsel_t mw_reg_sel;
    word_t   mw_alu_out;
    word_t   mw_load;

    // nothing behind HALT reaches the data bus
    assign dmem_ren   = ex_mem.ctrl.mem_read && !halt;
    assign dmem_wen   = ex_mem.ctrl.mem_write && !halt;
    assign dmem_addr  = ex_mem.alu_out;
    assign dmem_store = ex_mem.store_data;

    // keeps the load word while ihit is still pending
    always_ff @(posedge CLK)
    begin
        if (dhit)
            load_hold <= dmem_load;
    end

    assign load_data = dhit ? dmem_load : load_hold;

    // sticky until reset
    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
            halt <= 1'b0;
        else if (ex_mem.ctrl.halt)
            halt <= 1'b1;
    end

    // *************************************************************************
    // MEM/WB register
    // *************************************************************************
    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
            mw_reg_write <= 1'b0;
        else if (move)
            mw_reg_write <= ex_mem.ctrl.reg_write;
    end

    always_ff @(posedge CLK)
    begin
        if (move)
        begin
            mw_mem_to_reg <= ex_mem.ctrl.mem_to_reg;
            mw_reg_sel    <= ex_mem.reg_sel;
            mw_alu_out    <= ex_mem.alu_out;
            mw_load       <= load_data;
        end
    end

    assign wb.reg_write = mw_reg_write;
    assign wb.reg_sel   = mw_reg_sel;
    assign wb.wdat      = mw_mem_to_reg ? mw_load : mw_alu_out;

endmodule

/* verilog/hazard_unit.sv */
`timescale 1ns/10ps

module hazard_unit
    import cpu_pkg::*;
(
    input  logic  ihit,
    input  logic  dhit,
    input  logic  dmem_ren,
    input  logic  dmem_wen,
    input  word_t ifid_instr,
    id_ex_if.hazard id_ex,
    output logic  move,
    output logic  stall
);

    regsel_t id_rs;
    regsel_t id_rt;
    logic    data_req;

    assign id_rs = ifid_instr[RS_HI:RS_LO];
    assign id_rt = ifid_instr[RT_HI:RT_LO];

    // whole pipe advances only once every outstanding access is served
    assign data_req = dmem_ren || dmem_wen;
    assign move     = ihit && (data_req ? dhit : 1'b1);

    // load in EX feeding the instruction in ID
    assign stall = id_ex.ctrl.mem_read && (id_ex.rt != '0)
                   && ((id_ex.rt == id_rs) || (id_ex.rt == id_rt));

endmodule

/* verilog/datapath.sv */
`timescale 1ns/10ps

module datapath
    import cpu_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    output logic  imem_ren,
    output word_t imem_addr,
    input  word_t imem_load,
    input  logic  ihit,
    output logic  dmem_ren,
    output logic  dmem_wen,
    output word_t dmem_addr,
    output word_t dmem_store,
    input  word_t dmem_load,
    input  logic  dhit,
    output logic  halt
);

    logic  move;
    logic  stall;
    word_t ifid_instr;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();
    wb_if     wb ();

    // fetch stops once HALT has passed EX/MEM
    assign imem_ren = !halt;

    fetch_stage i_fetch_stage (
        .CLK, .nRST, .move, .stall, .halt,
        .imem_load, .imem_addr, .ifid_instr
    );

    decode_stage i_decode_stage (
        .CLK, .nRST, .move, .stall, .ifid_instr,
        .id_ex (id_ex.decode),
        .wb    (wb.decode)
    );

    execute_stage i_execute_stage (
        .CLK, .nRST, .move, .dhit,
        .id_ex  (id_ex.execute),
        .ex_mem (ex_mem.execute),
        .wb     (wb.execute)
    );

    memory_stage i_memory_stage (
        .CLK, .nRST, .move, .dhit, .dmem_load,
        .ex_mem (ex_mem.memory),
        .wb     (wb.memory),
        .dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .halt
    );

    hazard_unit i_hazard_unit (
        .ihit, .dhit, .dmem_ren, .dmem_wen, .ifid_instr,
        .id_ex (id_ex.hazard),
        .move, .stall
    );

endmodule

/* sim/datapath_properties.sv */
`timescale 1ns/10ps

module datapath_properties
    import cpu_pkg::*;
(
    input logic  CLK,
    input logic  nRST,
    input logic  imem_ren,
    input logic  dmem_ren,
    input logic  dmem_wen,
    input word_t dmem_addr,
    input word_t dmem_store,
    input logic  dhit,
    input logic  halt
);

    // ************************************************************************
    // data port rules
    // ************************************************************************
    one_access: assert property (@(posedge CLK) disable iff (!nRST)
        !(dmem_ren && dmem_wen))
        else $error("read and write strobes high together");

    // a pending access holds until the memory answers
    req_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (dmem_ren || dmem_wen) && !dhit |=>
            $stable(dmem_ren) && $stable(dmem_wen) && $stable(dmem_addr)
            && (!dmem_wen || $stable(dmem_store)))
        else $error("data request changed before dhit");

    // halt is sticky and keeps fetch off
    halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
        halt |=> halt && !imem_ren)
        else $error("halt dropped or fetch resumed");

endmodule

bind datapath datapath_properties i_datapath_properties (.*);

/* sim/datapath_tb.sv */
`timescale 1ns/10ps

module datapath_tb
    import cpu_pkg::*;
();

    localparam int    N_RANDOM    = 200;
    localparam word_t DATA_BASE   = 32'h0000_0100;
    localparam word_t RESULT_BASE = 32'h0000_0200;

    logic  CLK;
    logic  nRST;
    logic  imem_ren;
    word_t imem_addr;
    word_t imem_load;
    logic  ihit;
    logic  dmem_ren;
    logic  dmem_wen;
    word_t dmem_addr;
    word_t dmem_store;
    word_t dmem_load;
    logic  dhit;
    logic  halt;
    logic  pipe_moves;

    word_t prog [$];
    word_t mregs [NUM_REGS];
    word_t model_mem [word_t];
    word_t dmem [word_t];
    word_t exp_addr [$];
    word_t exp_data [$];
    int    n_stores;
    int    errors;
    int    writes;
    int    timeout_cycles;
    int    iwait;
    int    dwait;

    datapath i_datapath (
        .CLK, .nRST, .imem_ren, .imem_addr, .imem_load, .ihit,
        .dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .dmem_load, .dhit, .halt
    );

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;

    // advance rule of the memory interface as seen from outside
    assign pipe_moves = ihit && (!(dmem_ren || dmem_wen) || dhit);

    // ************************************************************************
    // reference helpers
    // ************************************************************************
    function automatic word_t fill_word(input word_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_5a5a;
    endfunction

    function automatic word_t enc_r(input funct_t f, input regsel_t rd,
                                    input regsel_t rs, input regsel_t rt);
        return {RTYPE, rs, rt, rd, 5'd0, f};
    endfunction

    function automatic word_t enc_i(input opcode_t op, input regsel_t rs,
                                    input regsel_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t model_load(input word_t a);
        return model_mem.exists(a) ? model_mem[a] : fill_word(a);
    endfunction

    function automatic word_t fetch_word(input word_t a);
        return ((a >> 2) < prog.size()) ? prog[a >> 2] : '0;
    endfunction

    function automatic word_t read_dmem(input word_t a);
        return dmem.exists(a) ? dmem[a] : fill_word(a);
    endfunction

    task automatic add_store(input regsel_t rt, input word_t ea);
        prog.push_back(enc_i(SW, 5'd0, rt, ea[15:0]));
        model_mem[ea] = mregs[rt];
        exp_addr.push_back(ea);
        exp_data.push_back(mregs[rt]);
        n_stores++;
    endtask

    // builds the program and runs it on the ISA model in one pass
    task automatic gen_program();
        int          kind;
        regsel_t     rd;
        regsel_t     rs;
        regsel_t     rt;
        logic [15:0] imm;
        word_t       a;
        word_t       b;
        word_t       ea;
        word_t       sx;
        for (int r = 0; r < NUM_REGS; r++)
            mregs[r] = '0;
        for (int i = 0; i < N_RANDOM; i++)
        begin
            kind = $urandom_range(13, 0);
            rd   = regsel_t'($urandom_range(7, 1));
            rs   = regsel_t'($urandom_range(7, 1));
            rt   = regsel_t'($urandom_range(7, 1));
            imm  = 16'($urandom());
            a    = mregs[rs];
            b    = mregs[rt];
            sx   = {{16{imm[15]}}, imm};
            ea   = DATA_BASE + 32'(4 * $urandom_range(15, 0));
            case (kind)
                0: prog.push_back(enc_r(ADDU, rd, rs, rt));
                1: prog.push_back(enc_r(SUBU, rd, rs, rt));
                2: prog.push_back(enc_r(AND, rd, rs, rt));
                3: prog.push_back(enc_r(OR, rd, rs, rt));
                4: prog.push_back(enc_r(XOR, rd, rs, rt));
                5: prog.push_back(enc_r(SLT, rd, rs, rt));
                6: prog.push_back(enc_i(ADDIU, rs, rd, imm));
                7: prog.push_back(enc_i(ANDI, rs, rd, imm));
                8: prog.push_back(enc_i(ORI, rs, rd, imm));
                9: prog.push_back(enc_i(LUI, 5'd0, rd, imm));
                10, 11: prog.push_back(enc_i(LW, 5'd0, rd, ea[15:0]));
                default: add_store(rt, ea);
            endcase
            case (kind)
                0: mregs[rd] = a + b;
                1: mregs[rd] = a - b;
                2: mregs[rd] = a & b;
                3: mregs[rd] = a | b;
                4: mregs[rd] = a ^ b;
                5: mregs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                6: mregs[rd] = a + sx;
                7: mregs[rd] = a & {16'd0, imm};
                8: mregs[rd] = a | {16'd0, imm};
                9: mregs[rd] = {imm, 16'd0};
                10, 11: mregs[rd] = model_load(ea);
                default: ;
            endcase
        end
        for (int r = 1; r < 8; r++)
            add_store(regsel_t'(r), RESULT_BASE + 32'(4 * r));
        prog.push_back({HALT, 26'd0});
    endtask

    // ************************************************************************
    // memory models
    // ************************************************************************
    task automatic record_store();
        word_t ea;
        word_t ed;
        writes++;
        dmem[dmem_addr] = dmem_store;
        assert (!halt)
        else
        begin
            $display("Error: data write seen after halt rose");
            errors++;
        end
        assert (exp_addr.size() != 0)
        else
        begin
            $display("Error: more data writes than the program stores");
            errors++;
        end
        if (exp_addr.size() != 0)
        begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            assert (dmem_addr == ea)
            else
            begin
                $display("Error dmem_addr: got %h expected %h", dmem_addr, ea);
                errors++;
            end
            assert (dmem_store == ed)
            else
            begin
                $display("Error dmem_store: got %h expected %h", dmem_store, ed);
                errors++;
            end
        end
    endtask

    // address settles one edge after a move, so ihit drops for that edge
    always @(posedge CLK)
    begin
        if (!nRST || pipe_moves)
        begin
            ihit  <= 1'b0;
            iwait = $urandom_range(3, 0);
        end
        else if (!ihit)
        begin
            if (iwait == 0)
            begin
                ihit      <= 1'b1;
                imem_load <= fetch_word(imem_addr);
            end
            else
                iwait--;
        end
    end

    always @(posedge CLK)
    begin
        if (!nRST)
        begin
            dhit  <= 1'b0;
            dwait = $urandom_range(3, 0);
        end
        else if (dhit)
        begin
            // request served at this edge
            if (dmem_wen)
                record_store();
            dhit  <= 1'b0;
            dwait = $urandom_range(3, 0);
        end
        else if (dmem_ren || dmem_wen)
        begin
            if (dwait == 0)
            begin
                dhit      <= 1'b1;
                dmem_load <= read_dmem(dmem_addr);
            end
            else
                dwait--;
        end
    end

    // ************************************************************************
    // watchdog
    // ************************************************************************
    initial
    begin
        wait (nRST === 1'b1);
        repeat (timeout_cycles) @(posedge CLK);
        $display("Error: timeout, halt did not rise within %0d cycles", timeout_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        nRST      = 1'b0;
        ihit      = 1'b0;
        dhit      = 1'b0;
        imem_load = '0;
        dmem_load = '0;
        errors    = 0;
        writes    = 0;
        n_stores  = 0;
        void'($urandom(73));
        gen_program();
        timeout_cycles = prog.size() * 5 * 8 + 100;
        repeat (8) @(posedge CLK);
        assert (!dmem_ren && !dmem_wen && !halt && imem_ren)
        else
        begin
            $display("Error: strobes in reset: ren %h wen %h halt %h imem_ren %h",
                     dmem_ren, dmem_wen, halt, imem_ren);
            errors++;
        end
        assert (imem_addr == 32'h0)
        else
        begin
            $display("Error imem_addr: got %h expected %h", imem_addr, 32'h0);
            errors++;
        end
        nRST <= 1'b1;
        while (!halt)
            @(posedge CLK);
        // let the pipe drain while watching for late writes
        repeat (20) @(posedge CLK);
        assert (halt && !imem_ren)
        else
        begin
            $display("Error: halt dropped or instruction fetch still enabled");
            errors++;
        end
        assert (writes == n_stores)
        else
        begin
            $display("Error writes: got %h expected %h", writes, n_stores);
            errors++;
        end
        $display("errors: %0d, data writes: %0d of %0d", errors, writes, n_stores);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* files.f */
verilog/cpu_pkg.sv
verilog/pipe_if.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/hazard_unit.sv
verilog/datapath.sv
sim/datapath_properties.sv
sim/datapath_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module datapath_tb -f files.f
./obj_dir/Vdatapath_tb 2>&1 | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log || ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
